// ==== Makefile ====
SRCS := $(shell cat state_cache.f)

.PHONY: all run clean

all: run

obj_dir/Vstate_cache_tb: state_cache.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module state_cache_tb -f state_cache.f

run: obj_dir/Vstate_cache_tb
	./obj_dir/Vstate_cache_tb +verilator+error+limit+100 | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Run failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" sim.log; then \
		echo "Run ended without a result, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== src/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // ----------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------
    typedef enum logic {
        OP_LOOKUP = 1'b0,
        OP_DELETE = 1'b1
    } op_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_DECIDE    = 3'd2,
        ST_DEL_READ  = 3'd3,
        ST_DEL_CHECK = 3'd4,
        ST_ACK       = 3'd5
    } fsm_state_t;

    // ----------------------------------------------------------
    // Statistics
    // ----------------------------------------------------------
    localparam int CNT_WID = 16;

    // One-hot, one pulse per lookup
    typedef struct packed {
        logic tracked_existing;
        logic tracked_new;
        logic not_tracked;
    } cnt_evt_t;

    typedef struct packed {
        logic [CNT_WID-1:0] req;
        logic [CNT_WID-1:0] tracked_existing;
        logic [CNT_WID-1:0] tracked_new;
        logic [CNT_WID-1:0] not_tracked;
    } cache_stats_t;

endpackage : cache_ctrl_pkg

// ==== src/cache_fsm.sv ====
`timescale 1ns/1ps

module cache_fsm (
    input  logic                        clk,
    input  logic                        htable_srst,
    input  logic                        i_req,
    input  cache_types_pkg::cache_cmd_t i_cmd,
    output logic                        o_ack,
    output cache_types_pkg::cache_rsp_t o_rsp,
    // Key table
    output cache_types_pkg::key_t       o_tbl_key,
    input  logic                        i_tbl_hit,
    input  logic                        i_tbl_slot_free,
    input  cache_types_pkg::id_t        i_tbl_id,
    output logic                        o_tbl_wr_en,
    output logic                        o_tbl_wr_valid,
    output cache_types_pkg::key_t       o_tbl_wr_key,
    output cache_types_pkg::id_t        o_tbl_wr_id,
    // ID allocator
    input  logic                        i_free_valid,
    input  cache_types_pkg::id_t        i_free_id,
    output logic                        o_alloc,
    output logic                        o_dealloc,
    output cache_types_pkg::id_t        o_dealloc_id,
    output cache_types_pkg::id_t        o_query_id,
    input  logic                        i_query_used,
    // Reverse map
    output logic                        o_rev_wr,
    output cache_types_pkg::id_t        o_rev_rd_id,
    input  cache_types_pkg::key_t       i_rev_key,
    // Statistics
    output cache_ctrl_pkg::cnt_evt_t    o_cnt_evt
);

    cache_ctrl_pkg::fsm_state_t  state;
    cache_ctrl_pkg::fsm_state_t  nxt_state;
    cache_types_pkg::cache_cmd_t cmd_q;
    cache_types_pkg::cache_rsp_t rsp_nxt;
    cache_ctrl_pkg::cnt_evt_t    evt_nxt;

    // Every lookup-side read is addressed by the latched command
    assign o_tbl_key    = cmd_q.key;
    assign o_dealloc_id = cmd_q.id;
    assign o_query_id   = cmd_q.id;
    assign o_rev_rd_id  = cmd_q.id;

    assign o_ack = (state == cache_ctrl_pkg::ST_ACK);

    // ----------------------------------------------------------
    // Next state and datapath strobes
    // ----------------------------------------------------------
    always_comb begin
        nxt_state      = state;
        rsp_nxt        = o_rsp;
        evt_nxt        = '0;
        o_tbl_wr_en    = 1'b0;
        o_tbl_wr_valid = 1'b0;
        o_tbl_wr_key   = cmd_q.key;
        o_tbl_wr_id    = i_free_id;
        o_alloc        = 1'b0;
        o_dealloc      = 1'b0;
        o_rev_wr       = 1'b0;
        case (state)
            cache_ctrl_pkg::ST_IDLE: begin
                if (i_req) begin
                    if (cache_ctrl_pkg::op_t'(i_cmd.op) == cache_ctrl_pkg::OP_DELETE) begin
                        nxt_state = cache_ctrl_pkg::ST_DEL_READ;
                    end else begin
                        nxt_state = cache_ctrl_pkg::ST_LOOKUP;
                    end
                end
            end
            // Table read in flight
            cache_ctrl_pkg::ST_LOOKUP: begin
                nxt_state = cache_ctrl_pkg::ST_DECIDE;
            end
            cache_ctrl_pkg::ST_DECIDE: begin
                nxt_state      = cache_ctrl_pkg::ST_ACK;
                rsp_nxt        = '0;
                rsp_nxt.key    = cmd_q.key;
                if (i_tbl_hit) begin
                    rsp_nxt.valid            = 1'b1;
                    rsp_nxt.id               = i_tbl_id;
                    evt_nxt.tracked_existing = 1'b1;
                end else if (i_tbl_slot_free && i_free_valid) begin
                    // Auto-insert with the lowest free ID
                    o_alloc             = 1'b1;
                    o_tbl_wr_en         = 1'b1;
                    o_tbl_wr_valid      = 1'b1;
                    o_rev_wr            = 1'b1;
                    rsp_nxt.valid       = 1'b1;
                    rsp_nxt.is_new      = 1'b1;
                    rsp_nxt.id          = i_free_id;
                    evt_nxt.tracked_new = 1'b1;
                end else begin
                    evt_nxt.not_tracked = 1'b1;
                end
            end
            // Reverse map read in flight
            cache_ctrl_pkg::ST_DEL_READ: begin
                nxt_state = cache_ctrl_pkg::ST_DEL_CHECK;
            end
            cache_ctrl_pkg::ST_DEL_CHECK: begin
                nxt_state  = cache_ctrl_pkg::ST_ACK;
                rsp_nxt    = '0;
                rsp_nxt.id = cmd_q.id;
                if (i_query_used) begin
                    // Empty the key's slot and release the ID
                    o_tbl_wr_en   = 1'b1;
                    o_tbl_wr_key  = i_rev_key;
                    o_dealloc     = 1'b1;
                    rsp_nxt.valid = 1'b1;
                    rsp_nxt.key   = i_rev_key;
                end else begin
                    rsp_nxt.error = 1'b1;
                end
            end
            cache_ctrl_pkg::ST_ACK: begin
                if (!i_req) begin
                    nxt_state = cache_ctrl_pkg::ST_IDLE;
                end
            end
            default: begin
                nxt_state = cache_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            state     <= cache_ctrl_pkg::ST_IDLE;
            o_cnt_evt <= '0;
        end else begin
            state     <= nxt_state;
            o_cnt_evt <= evt_nxt;
        end
    end

    // Command and response hold
    always_ff @(posedge clk) begin
        if (state == cache_ctrl_pkg::ST_IDLE && i_req) begin
            cmd_q <= i_cmd;
        end
        o_rsp <= rsp_nxt;
    end

endmodule : cache_fsm

// ==== src/cache_types_pkg.sv ====
package cache_types_pkg;

    // ----------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------
    localparam int KEY_WID       = 16;
    localparam int ID_WID        = 3;
    localparam int NUM_IDS       = 8;
    localparam int TABLE_IDX_WID = 4;
    localparam int TABLE_DEPTH   = 16;

    typedef logic [KEY_WID-1:0] key_t;
    typedef logic [ID_WID-1:0]  id_t;

    // ----------------------------------------------------------
    // Request and response payloads
    // ----------------------------------------------------------
    // Op bit decodes as cache_ctrl_pkg::op_t
    typedef struct packed {
        logic op;
        key_t key;
        id_t  id;
    } cache_cmd_t;

    typedef struct packed {
        logic valid;
        logic is_new;
        logic error;
        id_t  id;
        key_t key;
    } cache_rsp_t;

endpackage : cache_types_pkg

// ==== src/id_allocator.sv ====
`timescale 1ns/1ps

module id_allocator (
    input  logic                 clk,
    input  logic                 htable_srst,
    output logic                 o_free_valid,
    output cache_types_pkg::id_t o_free_id,
    input  logic                 i_alloc,
    input  logic                 i_dealloc,
    input  cache_types_pkg::id_t i_dealloc_id,
    input  cache_types_pkg::id_t i_query_id,
    output logic                 o_query_used
);

    logic [cache_types_pkg::NUM_IDS-1:0] used;

    // ----------------------------------------------------------
    // Lowest free ID
    // ----------------------------------------------------------
    always_comb begin
        o_free_id = '0;
        for (int i = cache_types_pkg::NUM_IDS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                o_free_id = cache_types_pkg::id_t'(i);
            end
        end
    end

    assign o_free_valid = !(&used);
    assign o_query_used = used[i_query_id];

    // Used bits, one per ID
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            used <= '0;
        end else begin
            if (i_alloc && o_free_valid) begin
                used[o_free_id] <= 1'b1;
            end
            if (i_dealloc) begin
                used[i_dealloc_id] <= 1'b0;
            end
        end
    end

endmodule : id_allocator

// ==== src/key_table.sv ====
`timescale 1ns/1ps

module key_table (
    input  logic                  clk,
    input  logic                  htable_srst,
    input  cache_types_pkg::key_t i_rd_key,
    output logic                  o_hit,
    output logic                  o_slot_free,
    output cache_types_pkg::id_t  o_rd_id,
    input  logic                  i_wr_en,
    input  logic                  i_wr_valid,
    input  cache_types_pkg::key_t i_wr_key,
    input  cache_types_pkg::id_t  i_wr_id
);

    // Slot index is the XOR of all key nibbles
    function automatic logic [cache_types_pkg::TABLE_IDX_WID-1:0] fold_idx(
        input cache_types_pkg::key_t key
    );
        logic [cache_types_pkg::TABLE_IDX_WID-1:0] idx;
        idx = '0;
        for (int n = 0; n < cache_types_pkg::KEY_WID / cache_types_pkg::TABLE_IDX_WID; n++) begin
            idx ^= key[n*cache_types_pkg::TABLE_IDX_WID +: cache_types_pkg::TABLE_IDX_WID];
        end
        return idx;
    endfunction

    logic [cache_types_pkg::TABLE_DEPTH-1:0] slot_valid;
    cache_types_pkg::key_t                   key_mem [cache_types_pkg::TABLE_DEPTH];
    cache_types_pkg::id_t                    id_mem  [cache_types_pkg::TABLE_DEPTH];

    logic [cache_types_pkg::TABLE_IDX_WID-1:0] rd_idx;
    logic [cache_types_pkg::TABLE_IDX_WID-1:0] wr_idx;

    assign rd_idx = fold_idx(i_rd_key);
    assign wr_idx = fold_idx(i_wr_key);

    // ----------------------------------------------------------
    // Valid bits and registered lookup flags
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst) begin
            slot_valid  <= '0;
            o_hit       <= 1'b0;
            o_slot_free <= 1'b0;
        end else begin
            o_hit       <= slot_valid[rd_idx] && (key_mem[rd_idx] == i_rd_key);
            o_slot_free <= !slot_valid[rd_idx];
            if (i_wr_en) begin
                slot_valid[wr_idx] <= i_wr_valid;
            end
        end
    end

    // Key and ID storage
    always_ff @(posedge clk) begin
        o_rd_id <= id_mem[rd_idx];
        if (i_wr_en && i_wr_valid) begin
            key_mem[wr_idx] <= i_wr_key;
            id_mem[wr_idx]  <= i_wr_id;
        end
    end

endmodule : key_table

// ==== src/reverse_map.sv ====
`timescale 1ns/1ps

module reverse_map (
    input  logic                  clk,
    input  logic                  i_wr,
    input  cache_types_pkg::id_t  i_wr_id,
    input  cache_types_pkg::key_t i_wr_key,
    input  cache_types_pkg::id_t  i_rd_id,
    output cache_types_pkg::key_t o_rd_key
);

    // ID-to-key storage, filled on insert
    cache_types_pkg::key_t key_mem [cache_types_pkg::NUM_IDS];

    always_ff @(posedge clk) begin
        if (i_wr) begin
            key_mem[i_wr_id] <= i_wr_key;
        end
        o_rd_key <= key_mem[i_rd_id];
    end

endmodule : reverse_map

// ==== src/stat_counters.sv ====
`timescale 1ns/1ps

module stat_counters (
    input  logic                         clk,
    input  logic                         htable_srst,
    input  cache_ctrl_pkg::cnt_evt_t     i_evt,
    input  logic                         i_clear,
    output cache_ctrl_pkg::cache_stats_t o_stats
);

    // ----------------------------------------------------------
    // Lookup outcome counters
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (htable_srst || i_clear) begin
            o_stats <= '0;
        end else begin
            // Any outcome is one request
            if (|i_evt) begin
                o_stats.req <= o_stats.req + 1'b1;
            end
            if (i_evt.tracked_existing) begin
                o_stats.tracked_existing <= o_stats.tracked_existing + 1'b1;
            end
            if (i_evt.tracked_new) begin
                o_stats.tracked_new <= o_stats.tracked_new + 1'b1;
            end
            if (i_evt.not_tracked) begin
                o_stats.not_tracked <= o_stats.not_tracked + 1'b1;
            end
        end
    end

endmodule : stat_counters

// ==== src/state_cache_top.sv ====
`timescale 1ns/1ps

module state_cache_top (
    input  logic                         clk,
    input  logic                         htable_srst,
    input  logic                         i_req,
    input  cache_types_pkg::cache_cmd_t  i_cmd,
    output logic                         o_ack,
    output cache_types_pkg::cache_rsp_t  o_rsp,
    input  logic                         i_stats_clear,
    output cache_ctrl_pkg::cache_stats_t o_stats
);

    // Key table
    cache_types_pkg::key_t tbl_key;
    logic                  tbl_hit;
    logic                  tbl_slot_free;
    cache_types_pkg::id_t  tbl_id;
    logic                  tbl_wr_en;
    logic                  tbl_wr_valid;
    cache_types_pkg::key_t tbl_wr_key;
    cache_types_pkg::id_t  tbl_wr_id;

    // Allocator
    logic                  free_valid;
    cache_types_pkg::id_t  free_id;
    logic                  alloc;
    logic                  dealloc;
    cache_types_pkg::id_t  dealloc_id;
    cache_types_pkg::id_t  query_id;
    logic                  query_used;

    // Reverse map
    logic                  rev_wr;
    cache_types_pkg::id_t  rev_rd_id;
    cache_types_pkg::key_t rev_key;

    cache_ctrl_pkg::cnt_evt_t cnt_evt;

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    cache_fsm u_cache_fsm (
        .clk             ( clk ),
        .htable_srst     ( htable_srst ),
        .i_req           ( i_req ),
        .i_cmd           ( i_cmd ),
        .o_ack           ( o_ack ),
        .o_rsp           ( o_rsp ),
        .o_tbl_key       ( tbl_key ),
        .i_tbl_hit       ( tbl_hit ),
        .i_tbl_slot_free ( tbl_slot_free ),
        .i_tbl_id        ( tbl_id ),
        .o_tbl_wr_en     ( tbl_wr_en ),
        .o_tbl_wr_valid  ( tbl_wr_valid ),
        .o_tbl_wr_key    ( tbl_wr_key ),
        .o_tbl_wr_id     ( tbl_wr_id ),
        .i_free_valid    ( free_valid ),
        .i_free_id       ( free_id ),
        .o_alloc         ( alloc ),
        .o_dealloc       ( dealloc ),
        .o_dealloc_id    ( dealloc_id ),
        .o_query_id      ( query_id ),
        .i_query_used    ( query_used ),
        .o_rev_wr        ( rev_wr ),
        .o_rev_rd_id     ( rev_rd_id ),
        .i_rev_key       ( rev_key ),
        .o_cnt_evt       ( cnt_evt )
    );

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    key_table u_key_table (
        .clk         ( clk ),
        .htable_srst ( htable_srst ),
        .i_rd_key    ( tbl_key ),
        .o_hit       ( tbl_hit ),
        .o_slot_free ( tbl_slot_free ),
        .o_rd_id     ( tbl_id ),
        .i_wr_en     ( tbl_wr_en ),
        .i_wr_valid  ( tbl_wr_valid ),
        .i_wr_key    ( tbl_wr_key ),
        .i_wr_id     ( tbl_wr_id )
    );

    id_allocator u_id_allocator (
        .clk          ( clk ),
        .htable_srst  ( htable_srst ),
        .o_free_valid ( free_valid ),
        .o_free_id    ( free_id ),
        .i_alloc      ( alloc ),
        .i_dealloc    ( dealloc ),
        .i_dealloc_id ( dealloc_id ),
        .i_query_id   ( query_id ),
        .o_query_used ( query_used )
    );

    // Insert writes share the table's write key and ID
    reverse_map u_reverse_map (
        .clk      ( clk ),
        .i_wr     ( rev_wr ),
        .i_wr_id  ( tbl_wr_id ),
        .i_wr_key ( tbl_wr_key ),
        .i_rd_id  ( rev_rd_id ),
        .o_rd_key ( rev_key )
    );

    stat_counters u_stat_counters (
        .clk         ( clk ),
        .htable_srst ( htable_srst ),
        .i_evt       ( cnt_evt ),
        .i_clear     ( i_stats_clear ),
        .o_stats     ( o_stats )
    );

endmodule : state_cache_top

// ==== state_cache.f ====
src/cache_types_pkg.sv
src/cache_ctrl_pkg.sv
src/key_table.sv
src/id_allocator.sv
src/reverse_map.sv
src/cache_fsm.sv
src/stat_counters.sv
src/state_cache_top.sv
tests/tb_clock_gen.sv
tests/state_cache_assertions.sv
tests/state_cache_tb.sv

// ==== tests/state_cache_assertions.sv ====
`timescale 1ns/1ps

module state_cache_assertions (
    input logic                        clk,
    input logic                        htable_srst,
    input logic                        i_req,
    input logic                        o_ack,
    input cache_types_pkg::cache_rsp_t o_rsp
);

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // ----------------------------------------------------------
    // Handshake
    // ----------------------------------------------------------
    ack_needs_req: assert property (@(posedge clk) disable iff (htable_srst)
        $rose(o_ack) |-> i_req)
    else begin
        fail_count++;
        $error("o_ack rose while i_req was low");
    end

    rsp_held: assert property (@(posedge clk) disable iff (htable_srst)
        (o_ack && $past(o_ack)) |-> (o_rsp == $past(o_rsp)))
    else begin
        fail_count++;
        $error("o_rsp changed while o_ack was high");
    end

    // Response fields
    new_is_valid: assert property (@(posedge clk) disable iff (htable_srst)
        o_ack |-> (!o_rsp.is_new || o_rsp.valid))
    else begin
        fail_count++;
        $error("o_rsp.is_new set without o_rsp.valid");
    end

    ack_low_in_reset: assert property (@(posedge clk) htable_srst |=> !o_ack)
    else begin
        fail_count++;
        $error("o_ack high during reset");
    end

endmodule : state_cache_assertions

bind state_cache_top state_cache_assertions u_assertions (
    .clk         ( clk ),
    .htable_srst ( htable_srst ),
    .i_req       ( i_req ),
    .o_ack       ( o_ack ),
    .o_rsp       ( o_rsp )
);

// ==== tests/state_cache_tb.sv ====
`timescale 1ns/1ps

module state_cache_tb;

    localparam int NUM_DIRECTED = 22;
    localparam int NUM_RANDOM   = 12;
    localparam int NUM_ENTRIES  = NUM_DIRECTED + NUM_RANDOM;

    // One table row, expected response filled by the model when from_model is set
    typedef struct packed {
        logic                        op;
        cache_types_pkg::key_t       key;
        cache_types_pkg::id_t        id;
        logic                        from_model;
        cache_types_pkg::cache_rsp_t exp;
    } entry_t;

    logic                         clk;
    logic                         htable_srst;
    logic                         i_req;
    cache_types_pkg::cache_cmd_t  i_cmd;
    logic                         o_ack;
    cache_types_pkg::cache_rsp_t  o_rsp;
    logic                         i_stats_clear;
    cache_ctrl_pkg::cache_stats_t o_stats;

    entry_t      stim [NUM_ENTRIES];
    int unsigned err_count = 0;

    // Reference model state
    logic [cache_types_pkg::TABLE_DEPTH-1:0] m_slot_valid;
    cache_types_pkg::key_t m_slot_key [cache_types_pkg::TABLE_DEPTH];
    cache_types_pkg::id_t  m_slot_id  [cache_types_pkg::TABLE_DEPTH];
    logic [cache_types_pkg::NUM_IDS-1:0] m_used;
    cache_types_pkg::key_t m_rev [cache_types_pkg::NUM_IDS];
    int unsigned m_lookups;
    int unsigned m_existing;
    int unsigned m_new;
    int unsigned m_not_tracked;

    tb_clock_gen u_clock_gen (
        .o_clk  ( clk ),
        .o_srst ( htable_srst )
    );

    state_cache_top UUT (
        .clk           ( clk ),
        .htable_srst   ( htable_srst ),
        .i_req         ( i_req ),
        .i_cmd         ( i_cmd ),
        .o_ack         ( o_ack ),
        .o_rsp         ( o_rsp ),
        .i_stats_clear ( i_stats_clear ),
        .o_stats       ( o_stats )
    );

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_rsp(input cache_types_pkg::cache_rsp_t got,
                             input cache_types_pkg::cache_rsp_t exp);
        check_value("o_rsp.valid", got.valid, exp.valid);
        check_value("o_rsp.is_new", got.is_new, exp.is_new);
        check_value("o_rsp.error", got.error, exp.error);
        // ID and key only carry meaning on a valid response
        if (exp.valid) begin
            check_value("o_rsp.id", got.id, exp.id);
            check_value("o_rsp.key", got.key, exp.key);
        end
    endtask

    task automatic check_stats();
        check_value("o_stats.req", o_stats.req, m_lookups);
        check_value("o_stats.tracked_existing", o_stats.tracked_existing, m_existing);
        check_value("o_stats.tracked_new", o_stats.tracked_new, m_new);
        check_value("o_stats.not_tracked", o_stats.not_tracked, m_not_tracked);
    endtask

    // ----------------------------------------------------------
    // Reference model
    // ----------------------------------------------------------
    function automatic logic [3:0] slot_of(input cache_types_pkg::key_t key);
        return key[15:12] ^ key[11:8] ^ key[7:4] ^ key[3:0];
    endfunction

    task automatic model_step(inout entry_t e);
        logic [3:0]                  idx;
        cache_types_pkg::cache_rsp_t rsp;
        int                          free_id;
        rsp = '0;
        free_id = -1;
        for (int i = 0; i < cache_types_pkg::NUM_IDS; i++) begin
            if (!m_used[i] && free_id < 0) begin
                free_id = i;
            end
        end
        if (e.op == cache_ctrl_pkg::OP_LOOKUP) begin
            idx = slot_of(e.key);
            rsp.key = e.key;
            m_lookups++;
            if (m_slot_valid[idx] && m_slot_key[idx] == e.key) begin
                rsp.valid = 1'b1;
                rsp.id = m_slot_id[idx];
                m_existing++;
            end else if (!m_slot_valid[idx] && free_id >= 0) begin
                rsp.valid = 1'b1;
                rsp.is_new = 1'b1;
                rsp.id = cache_types_pkg::id_t'(free_id);
                m_slot_valid[idx] = 1'b1;
                m_slot_key[idx] = e.key;
                m_slot_id[idx] = rsp.id;
                m_used[free_id] = 1'b1;
                m_rev[free_id] = e.key;
                m_new++;
            end else begin
                m_not_tracked++;
            end
        end else begin
            rsp.id = e.id;
            if (m_used[e.id]) begin
                rsp.valid = 1'b1;
                rsp.key = m_rev[e.id];
                m_slot_valid[slot_of(rsp.key)] = 1'b0;
                m_used[e.id] = 1'b0;
            end else begin
                rsp.error = 1'b1;
            end
        end
        if (e.from_model) begin
            e.exp = rsp;
        end
    endtask

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    function automatic entry_t lookup_entry(input cache_types_pkg::key_t key, input logic v,
                                            input logic n, input cache_types_pkg::id_t id);
        entry_t e;
        e = '0;
        e.op = cache_ctrl_pkg::OP_LOOKUP;
        e.key = key;
        e.exp = '{valid: v, is_new: n, error: 1'b0, id: id, key: key};
        return e;
    endfunction

    function automatic entry_t delete_entry(input cache_types_pkg::id_t id, input logic v,
                                            input cache_types_pkg::key_t key);
        entry_t e;
        e = '0;
        e.op = cache_ctrl_pkg::OP_DELETE;
        e.id = id;
        e.exp = '{valid: v, is_new: 1'b0, error: !v, id: id, key: key};
        return e;
    endfunction

    task automatic build_table();
        // First insert, repeat hit, slot collision (0x2134 folds to slot 4 as well)
        stim[0]  = lookup_entry(16'h1234, 1'b1, 1'b1, 3'd0);
        stim[1]  = lookup_entry(16'h1234, 1'b1, 1'b0, 3'd0);
        stim[2]  = lookup_entry(16'h2134, 1'b0, 1'b0, 3'd0);
        // Fill the remaining IDs, one slot each
        stim[3]  = lookup_entry(16'h0010, 1'b1, 1'b1, 3'd1);
        stim[4]  = lookup_entry(16'h0020, 1'b1, 1'b1, 3'd2);
        stim[5]  = lookup_entry(16'h0030, 1'b1, 1'b1, 3'd3);
        stim[6]  = lookup_entry(16'h0050, 1'b1, 1'b1, 3'd4);
        stim[7]  = lookup_entry(16'h0060, 1'b1, 1'b1, 3'd5);
        stim[8]  = lookup_entry(16'h0070, 1'b1, 1'b1, 3'd6);
        stim[9]  = lookup_entry(16'h0080, 1'b1, 1'b1, 3'd7);
        // Empty slot but no ID left
        stim[10] = lookup_entry(16'h0090, 1'b0, 1'b0, 3'd0);
        // Deletes, then re-inserts take the lowest free ID
        stim[11] = delete_entry(3'd2, 1'b1, 16'h0020);
        stim[12] = delete_entry(3'd5, 1'b1, 16'h0060);
        stim[13] = lookup_entry(16'h0060, 1'b1, 1'b1, 3'd2);
        stim[14] = lookup_entry(16'h0020, 1'b1, 1'b1, 3'd5);
        stim[15] = delete_entry(3'd7, 1'b1, 16'h0080);
        stim[16] = delete_entry(3'd7, 1'b0, 16'h0000);
        stim[17] = lookup_entry(16'h0080, 1'b1, 1'b1, 3'd7);
        // Free some IDs for the random part
        stim[18] = delete_entry(3'd0, 1'b1, 16'h1234);
        stim[19] = delete_entry(3'd1, 1'b1, 16'h0010);
        stim[20] = delete_entry(3'd3, 1'b1, 16'h0030);
        stim[21] = delete_entry(3'd4, 1'b1, 16'h0050);
        for (int t = NUM_DIRECTED; t < NUM_ENTRIES; t++) begin
            stim[t] = '0;
            stim[t].from_model = 1'b1;
            stim[t].op = ($urandom % 4 == 0);
            stim[t].id = cache_types_pkg::id_t'($urandom % cache_types_pkg::NUM_IDS);
            // Reuse the previous key now and then to get hits
            if ($urandom % 3 == 0) begin
                stim[t].key = stim[t-1].key;
            end else begin
                stim[t].key = cache_types_pkg::key_t'($urandom);
            end
        end
    endtask

    // ----------------------------------------------------------
    // Four-phase request
    // ----------------------------------------------------------
    task automatic run_op(input entry_t e, output cache_types_pkg::cache_rsp_t rsp);
        @(posedge clk);
        i_cmd.op  <= e.op;
        i_cmd.key <= e.key;
        i_cmd.id  <= e.id;
        i_req     <= 1'b1;
        do @(negedge clk); while (!o_ack);
        rsp = o_rsp;
        @(posedge clk);
        i_req <= 1'b0;
        do @(negedge clk); while (o_ack);
    endtask

    initial begin
        repeat (NUM_ENTRIES * 50) @(posedge clk);
        $display("Timeout: the req/ack handshake hung after %0d cycles", NUM_ENTRIES * 50);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        entry_t                      e;
        cache_types_pkg::cache_rsp_t rsp;
        int unsigned                 errs_before;
        int unsigned                 total;
        void'($urandom(68597));
        i_req = 1'b0;
        i_cmd = '0;
        i_stats_clear = 1'b0;
        m_slot_valid = '0;
        m_used = '0;
        m_lookups = 0;
        m_existing = 0;
        m_new = 0;
        m_not_tracked = 0;
        build_table();
        @(posedge clk);
        wait (htable_srst === 1'b0);

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            errs_before = err_count;
            e = stim[t];
            model_step(e);
            run_op(e, rsp);
            check_rsp(rsp, e.exp);
            check_stats();
            $display("test %0d %s key 0x%04h id %0d: %s", t, e.op ? "delete" : "lookup",
                     e.key, e.id, (err_count == errs_before) ? "ok" : "mismatch");
        end

        // Counter clear
        errs_before = err_count;
        @(posedge clk);
        i_stats_clear <= 1'b1;
        @(posedge clk);
        i_stats_clear <= 1'b0;
        @(negedge clk);
        m_lookups = 0;
        m_existing = 0;
        m_new = 0;
        m_not_tracked = 0;
        check_stats();
        $display("test %0d stats clear: %s", NUM_ENTRIES,
                 (err_count == errs_before) ? "ok" : "mismatch");

        total = err_count + UUT.u_assertions.fail_count;
        $display("Summary: %0d tests, %0d check errors, %0d assertion failures",
                 NUM_ENTRIES + 1, err_count, UUT.u_assertions.fail_count);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : state_cache_tb

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_srst
);

    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // Reset held for the first 4 rising edges
    initial begin
        o_srst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_srst <= 1'b0;
    end

endmodule : tb_clock_gen
